/* source/dot_matrix_pkg.sv */
package dot_matrix_pkg;

    // matrix geometry.
    localparam int MATRIX_ROWS = 8;
    localparam int MATRIX_COLS = 8;

    // countdown pacing.
    localparam int STEP_CYCLES = 64;  // clocks per digit step.
    localparam int START_DIGIT = 7;
    localparam int STEP_BITS   = $clog2(STEP_CYCLES);

    // displayed digit, 0 to 7.
    typedef logic [2:0] digit_t;

    // row number on the matrix.
    typedef logic [$clog2(MATRIX_ROWS)-1:0] row_idx_t;

    // one row of columns, bit 7 is the leftmost dot.
    typedef logic [MATRIX_COLS-1:0] col_bits_t;

    typedef enum logic [1:0]
    {
        color_red,
        color_yellow,  // both leds lit.
        color_green
    } color_t;

    // colour rule: high digits red, middle yellow, low green.
    function automatic color_t color_of(input digit_t d);
        if (d >= digit_t'(4))
        begin
            return color_red;
        end
        else if (d >= digit_t'(2))
        begin
            return color_yellow;
        end
        else
        begin
            return color_green;
        end
    endfunction

endpackage

/* source/frame_wr_if.sv */
`timescale 1ns/1ps

interface frame_wr_if
    import dot_matrix_pkg::*;
();

    logic      wr_en;     // one row per strobe.
    row_idx_t  wr_row;
    col_bits_t wr_red;
    col_bits_t wr_green;
    logic      commit;    // back page is complete.

    modport render
    (
        output wr_en, wr_row, wr_red, wr_green, commit
    );

    modport store
    (
        input wr_en, wr_row, wr_red, wr_green, commit
    );

endinterface

/* source/countdown_render.sv */
`timescale 1ns/1ps

module countdown_render
    import dot_matrix_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         st,
    output digit_t       digit,
    output logic         running,
    frame_wr_if.render   wr
);

    localparam int RND_BITS = $clog2(MATRIX_ROWS + 1);
    localparam logic [RND_BITS-1:0] COMMIT_SLOT = RND_BITS'(MATRIX_ROWS);
    localparam logic [STEP_BITS-1:0] STEP_LAST = STEP_BITS'(STEP_CYCLES - 1);

    // glyph table, indexed [digit][row].
    localparam col_bits_t GLYPH [8][MATRIX_ROWS] = '{
        '{8'h00, 8'h3c, 8'h42, 8'h42, 8'h42, 8'h42, 8'h42, 8'h3c},  // 0.
        '{8'h00, 8'h18, 8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h7e},  // 1.
        '{8'h00, 8'h3c, 8'h66, 8'h06, 8'h0c, 8'h30, 8'h60, 8'h7e},  // 2.
        '{8'h00, 8'h3c, 8'h66, 8'h06, 8'h1c, 8'h06, 8'h66, 8'h3c},  // 3.
        '{8'h00, 8'h0c, 8'h1c, 8'h2c, 8'h4c, 8'h7e, 8'h0c, 8'h0c},  // 4.
        '{8'h00, 8'h7e, 8'h60, 8'h7c, 8'h06, 8'h06, 8'h66, 8'h3c},  // 5.
        '{8'h00, 8'h3c, 8'h60, 8'h7c, 8'h66, 8'h66, 8'h66, 8'h3c},  // 6.
        '{8'h00, 8'h7e, 8'h06, 8'h0c, 8'h18, 8'h30, 8'h30, 8'h30}   // 7.
    };

    logic [STEP_BITS-1:0] step_cnt;
    logic                 step_hit;
    logic                 digit_chg;
    logic                 rnd_act;
    logic [RND_BITS-1:0]  rnd_cnt;
    row_idx_t             rnd_row;
    col_bits_t            glyph_bits;
    color_t               color;

    assign step_hit  = running && (step_cnt == STEP_LAST);
    assign digit_chg = st || step_hit;  // digit loads or steps on this edge.

    // step prescaler and down counter.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            digit    <= '0;
            running  <= 1'b0;
            step_cnt <= '0;
        end
        else if (st)
        begin
            digit    <= digit_t'(START_DIGIT);
            running  <= 1'b1;
            step_cnt <= '0;
        end
        else if (running)
        begin
            if (step_hit)
            begin
                step_cnt <= '0;
                digit    <= digit - digit_t'(1);
                if (digit == digit_t'(1))
                    running <= 1'b0;  // hold at zero.
            end
            else
            begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

    // render walks rows 0..7, then one commit slot.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rnd_act <= 1'b0;
            rnd_cnt <= '0;
        end
        else if (digit_chg)
        begin
            rnd_act <= 1'b1;  // restart on any change.
            rnd_cnt <= '0;
        end
        else if (rnd_act)
        begin
            if (rnd_cnt == COMMIT_SLOT)
                rnd_act <= 1'b0;
            else
                rnd_cnt <= rnd_cnt + 1'b1;
        end
    end

    assign rnd_row    = row_idx_t'(rnd_cnt);
    assign glyph_bits = GLYPH[digit][rnd_row];
    assign color      = color_of(digit);

    always_comb
    begin
        wr.wr_red   = '0;
        wr.wr_green = '0;
        case (color)
            color_red:    wr.wr_red = glyph_bits;
            color_yellow:
            begin
                wr.wr_red   = glyph_bits;
                wr.wr_green = glyph_bits;
            end
            default:      wr.wr_green = glyph_bits;
        endcase
    end

    assign wr.wr_en  = rnd_act && (rnd_cnt != COMMIT_SLOT);
    assign wr.wr_row = rnd_row;
    assign wr.commit = rnd_act && (rnd_cnt == COMMIT_SLOT);

endmodule

/* source/frame_buffer.sv */
`timescale 1ns/1ps

module frame_buffer
    import dot_matrix_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    frame_wr_if.store  wr,
    input  row_idx_t   rd_row,
    output col_bits_t  rd_red,
    output col_bits_t  rd_green
);

    col_bits_t red_mem   [2][MATRIX_ROWS];
    col_bits_t green_mem [2][MATRIX_ROWS];

    logic front_sel;  // page being scanned.
    logic back_sel;
    logic swap_pend;
    logic swap;

    assign back_sel = ~front_sel;

    // swap only after the last row is addressed, so a frame is never split.
    assign swap = swap_pend && !wr.wr_en && (rd_row == row_idx_t'(MATRIX_ROWS - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int p = 0; p < 2; p++)
            begin
                for (int r = 0; r < MATRIX_ROWS; r++)
                begin
                    red_mem[p][r]   <= '0;
                    green_mem[p][r] <= '0;
                end
            end
        end
        else if (wr.wr_en)
        begin
            red_mem[back_sel][wr.wr_row]   <= wr.wr_red;
            green_mem[back_sel][wr.wr_row] <= wr.wr_green;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            front_sel <= 1'b0;
            swap_pend <= 1'b0;
        end
        else
        begin
            // a new render overwrites the back page, drop any stale commit.
            if (wr.wr_en)
                swap_pend <= 1'b0;
            else if (wr.commit)
                swap_pend <= 1'b1;
            else if (swap)
                swap_pend <= 1'b0;

            if (swap)
                front_sel <= back_sel;
        end
    end

    // registered read from the front page.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rd_red   <= '0;
            rd_green <= '0;
        end
        else
        begin
            rd_red   <= red_mem[front_sel][rd_row];
            rd_green <= green_mem[front_sel][rd_row];
        end
    end

endmodule

/* source/matrix_scan.sv */
`timescale 1ns/1ps

module matrix_scan
    import dot_matrix_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    output row_idx_t  rd_row,
    input  col_bits_t rd_red,
    input  col_bits_t rd_green,
    output col_bits_t row,
    output col_bits_t colr,
    output col_bits_t colg
);

    row_idx_t scan_row;  // row whose data is on rd_red/rd_green.
    logic     scan_vld;

    // free running, one row per clock.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            rd_row <= '0;
        else
            rd_row <= rd_row + 1'b1;
    end

    // delayed copy tracks the buffer read latency.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan_row <= '0;
            scan_vld <= 1'b0;
        end
        else
        begin
            scan_row <= rd_row;
            scan_vld <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= '1;  // all rows off.
            colr <= '0;
            colg <= '0;
        end
        else
        begin
            row  <= scan_vld ? ~(col_bits_t'(1) << scan_row) : '1;
            colr <= rd_red;
            colg <= rd_green;
        end
    end

endmodule

/* source/dot_matrix_top.sv */
`timescale 1ns/1ps

module dot_matrix_top
    import dot_matrix_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      st,
    output col_bits_t row,
    output col_bits_t colr,
    output col_bits_t colg,
    output digit_t    digit,
    output logic      running
);

    frame_wr_if wr_if ();

    row_idx_t  rd_row;
    col_bits_t rd_red;
    col_bits_t rd_green;

    // countdown and glyph renderer.
    countdown_render countdown_render_i
    (
        .clk     (clk),
        .rst     (rst),
        .st      (st),
        .digit   (digit),
        .running (running),
        .wr      (wr_if.render)
    );

    frame_buffer frame_buffer_i
    (
        .clk      (clk),
        .rst      (rst),
        .wr       (wr_if.store),
        .rd_row   (rd_row),
        .rd_red   (rd_red),
        .rd_green (rd_green)
    );

    // row scan out to the matrix.
    matrix_scan matrix_scan_i
    (
        .clk      (clk),
        .rst      (rst),
        .rd_row   (rd_row),
        .rd_red   (rd_red),
        .rd_green (rd_green),
        .row      (row),
        .colr     (colr),
        .colg     (colg)
    );

endmodule

/* verif/dot_matrix_tb.sv */
`timescale 1ns/1ps

module dot_matrix_tb
    import dot_matrix_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 3000;
    localparam int SHOW_LIMIT     = 30;  // clocks from a digit change to a full frame.
    localparam int BLANK          = 8;   // class of an empty frame.

    // reference glyphs indexed [digit][row] with bit 7 as the leftmost dot.
    localparam col_bits_t GLYPH_TB [8][MATRIX_ROWS] = '{
        '{8'h00, 8'h3c, 8'h42, 8'h42, 8'h42, 8'h42, 8'h42, 8'h3c},
        '{8'h00, 8'h18, 8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h7e},
        '{8'h00, 8'h3c, 8'h66, 8'h06, 8'h0c, 8'h30, 8'h60, 8'h7e},
        '{8'h00, 8'h3c, 8'h66, 8'h06, 8'h1c, 8'h06, 8'h66, 8'h3c},
        '{8'h00, 8'h0c, 8'h1c, 8'h2c, 8'h4c, 8'h7e, 8'h0c, 8'h0c},
        '{8'h00, 8'h7e, 8'h60, 8'h7c, 8'h06, 8'h06, 8'h66, 8'h3c},
        '{8'h00, 8'h3c, 8'h60, 8'h7c, 8'h66, 8'h66, 8'h66, 8'h3c},
        '{8'h00, 8'h7e, 8'h06, 8'h0c, 8'h18, 8'h30, 8'h30, 8'h30}
    };

    logic      clk;
    logic      rst;
    logic      st;
    col_bits_t row;
    col_bits_t colr;
    col_bits_t colg;
    digit_t    digit;
    logic      running;

    int        cycle_cnt;
    int        errors;
    int        tests_run;
    int        tests_failed;
    int        last_change;  // cycle of the latest digit change.
    integer    seed;
    col_bits_t cap_red   [MATRIX_ROWS];
    col_bits_t cap_green [MATRIX_ROWS];

    dot_matrix_top dot_matrix_top_i
    (
        .clk     (clk),
        .rst     (rst),
        .st      (st),
        .row     (row),
        .colr    (colr),
        .colg    (colg),
        .digit   (digit),
        .running (running)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // watchdog on the total run length.
    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // red for 7..2 and green for 3..0 so 3 and 2 are yellow.
    function automatic col_bits_t red_row(input int d, input int r);
        return (d >= 2) ? GLYPH_TB[d][r] : '0;
    endfunction

    function automatic col_bits_t green_row(input int d, input int r);
        return (d <= 3) ? GLYPH_TB[d][r] : '0;
    endfunction

    // position of the single low bit or -1 when there is not exactly one.
    function automatic int low_bit(input col_bits_t r);
        int idx;
        int cnt;
        idx = -1;
        cnt = 0;
        for (int i = 0; i < MATRIX_COLS; i++)
        begin
            if (!r[i])
            begin
                idx = i;
                cnt++;
            end
        end
        return (cnt == 1) ? idx : -1;
    endfunction

    // digit shown by the captured frame or BLANK or -1.
    function automatic int classify_frame();
        bit blank;
        bit hit;
        blank = 1'b1;
        for (int r = 0; r < MATRIX_ROWS; r++)
            if (cap_red[r] !== '0 || cap_green[r] !== '0)
                blank = 1'b0;
        if (blank)
            return BLANK;
        for (int d = 0; d < 8; d++)
        begin
            hit = 1'b1;
            for (int r = 0; r < MATRIX_ROWS; r++)
                if (cap_red[r] !== red_row(d, r) || cap_green[r] !== green_row(d, r))
                    hit = 1'b0;
            if (hit)
                return d;
        end
        return -1;
    endfunction

    task automatic check_digit(input string name, input digit_t exp, input digit_t act);
        if (act !== exp)
        begin
            $display("FAILED %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_cols(input string name, input col_bits_t exp, input col_bits_t act);
        if (act !== exp)
        begin
            $display("FAILED %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("FAILED %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        errors++;
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before)
        begin
            $display("test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    // st is high for one rising edge and the digit loads on that edge.
    task automatic pulse_start(output int change_cycle);
        @(posedge clk);
        #1 st = 1'b1;
        @(posedge clk);
        #1 st = 1'b0;
        @(negedge clk);
        change_cycle = cycle_cnt;
    endtask

    // one frame from row 0 to row 7 sampled at falling edges.
    task automatic capture_frame(output int cls, output int end_cycle);
        int        waited;
        col_bits_t exp_row;
        waited = 0;
        @(negedge clk);
        while (low_bit(row) != 0 && waited < 2 * MATRIX_ROWS)
        begin
            @(negedge clk);
            waited++;
        end
        if (low_bit(row) != 0)
        begin
            report_error("row 0 was never selected by the scan");
            cls = -1;
            end_cycle = cycle_cnt;
            return;
        end
        for (int i = 0; i < MATRIX_ROWS; i++)
        begin
            if (i > 0)
                @(negedge clk);
            exp_row    = '1;
            exp_row[i] = 1'b0;  // exactly one low bit with rows in order.
            check_cols("row", exp_row, row);
            cap_red[i]   = colr;
            cap_green[i] = colg;
        end
        cls = classify_frame();
        end_cycle = cycle_cnt;
    endtask

    task automatic compare_frame(input int d);
        for (int r = 0; r < MATRIX_ROWS; r++)
        begin
            check_cols($sformatf("colr[%0d]", r), red_row(d, r), cap_red[r]);
            check_cols($sformatf("colg[%0d]", r), green_row(d, r), cap_green[r]);
        end
    endtask

    // frames may show an allowed older display until the new digit appears.
    task automatic wait_for_frame(input int expected, input logic [8:0] allowed,
                                  input int change_cycle);
        int cls;
        int end_cycle;
        bit done;
        done = 1'b0;
        while (!done)
        begin
            capture_frame(cls, end_cycle);
            if (cls == expected)
            begin
                if (end_cycle - change_cycle > SHOW_LIMIT)
                    report_error($sformatf("digit %0d took %0d clocks to show",
                                           expected, end_cycle - change_cycle));
                done = 1'b1;
            end
            else if (cls < 0 || !allowed[cls])
            begin
                report_error($sformatf("frame is neither digit %0d nor the old display",
                                       expected));
                compare_frame(expected);
                done = 1'b1;
            end
            else if (end_cycle - change_cycle > SHOW_LIMIT)
            begin
                report_error($sformatf("digit %0d not shown within %0d clocks",
                                       expected, SHOW_LIMIT));
                done = 1'b1;
            end
        end
    endtask

    task automatic wait_step(input digit_t prev);
        int gap;
        while (digit === prev && cycle_cnt - last_change <= STEP_CYCLES + 2)
            @(negedge clk);
        gap = cycle_cnt - last_change;
        if (digit === prev)
            report_error($sformatf("digit stayed at %0d", prev));
        else if (gap != STEP_CYCLES)
            report_error($sformatf("digit stepped after %0d clocks, expected %0d",
                                   gap, STEP_CYCLES));
        last_change = cycle_cnt;
        check_digit("digit", digit_t'(prev - 1), digit);
    endtask

    task automatic reset_state_test();
        int e0;
        int cls;
        int end_cycle;
        e0 = errors;
        @(posedge clk);
        @(negedge clk);
        check_cols("row", 8'hff, row);  // still in reset.
        check_cols("colr", 8'h00, colr);
        check_cols("colg", 8'h00, colg);
        check_digit("digit", digit_t'(0), digit);
        check_flag("running", 1'b0, running);
        @(posedge clk);
        #1 rst = 1'b0;
        capture_frame(cls, end_cycle);
        if (cls != BLANK)
            report_error("frame after reset is not blank");
        check_digit("digit", digit_t'(0), digit);
        check_flag("running", 1'b0, running);
        finish_test("reset_state", e0);
    endtask

    task automatic start_test();
        int e0;
        e0 = errors;
        pulse_start(last_change);
        check_digit("digit", digit_t'(START_DIGIT), digit);
        check_flag("running", 1'b1, running);
        wait_for_frame(START_DIGIT, 9'h100, last_change);
        finish_test("start", e0);
    endtask

    task automatic stepping_test();
        int e0;
        e0 = errors;
        for (int d = START_DIGIT - 1; d >= 0; d--)
        begin
            wait_step(digit_t'(d + 1));
            check_flag("running", d != 0, running);
            wait_for_frame(d, 9'b1 << (d + 1), last_change);
        end
        finish_test("stepping", e0);
    endtask

    task automatic hold_zero_test();
        int e0;
        int start;
        int cls;
        int end_cycle;
        e0 = errors;
        check_flag("running", 1'b0, running);
        start = cycle_cnt;
        while (cycle_cnt - start < 2 * STEP_CYCLES)
        begin
            capture_frame(cls, end_cycle);
            if (cls != 0)
            begin
                report_error("frame at zero is not a green 0");
                compare_frame(0);
            end
            check_digit("digit", digit_t'(0), digit);
            check_flag("running", 1'b0, running);
        end
        finish_test("hold_zero", e0);
    endtask

    task automatic restart_test();
        int e0;
        int off;
        int cls;
        int end_cycle;
        e0 = errors;
        pulse_start(last_change);
        check_digit("digit", digit_t'(START_DIGIT), digit);
        wait_for_frame(START_DIGIT, 9'h001, last_change);
        for (int d = START_DIGIT - 1; d >= 3; d--)
            wait_step(digit_t'(d + 1));
        off = int'($unsigned($random(seed)) % (STEP_CYCLES - 8)) + 1;
        repeat (off - 1) @(negedge clk);
        check_digit("digit", digit_t'(3), digit);
        pulse_start(last_change);
        check_digit("digit", digit_t'(START_DIGIT), digit);
        check_flag("running", 1'b1, running);
        wait_for_frame(START_DIGIT, 9'h018, last_change);  // 3 or 4 may linger.
        capture_frame(cls, end_cycle);
        if (cls != START_DIGIT)
            report_error("display left glyph 7 after the restart");
        finish_test("restart", e0);
    endtask

    initial
    begin
        rst          = 1'b1;
        st           = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        last_change  = 0;
        seed         = 50638;
        reset_state_test();
        start_test();
        stepping_test();
        hold_zero_test();
        restart_test();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* src.f */
source/dot_matrix_pkg.sv
source/frame_wr_if.sv
source/countdown_render.sv
source/frame_buffer.sv
source/matrix_scan.sv
source/dot_matrix_top.sv
verif/dot_matrix_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dot_matrix_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= TEST RESULT: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
